// File: tests/bitproc_vectors.txt
# op lt type flow arqn seqn bad_hec rx_buf_stop exp_state, all hex
# exp_state is {seqn_old, arqn, remote_flow, tx_seqn, acked} of link lt after the test
rx 1 1 1 0 1 0 0 1c
rx 1 3 1 1 1 0 0 1f
rx 1 3 0 0 0 1 0 17
tx 1 4 0 0 0 0 0 17
rx 1 4 0 0 0 0 0 0a
tx 1 4 0 0 0 0 1 0a
rx 0 1 1 1 1 0 0 1f
rx 5 1 0 1 0 1 0 00
rx 5 2 1 1 0 0 0 0f
tx 5 1 0 0 0 0 0 0f
rx 7 f 1 0 1 0 0 1c
tx 7 2 0 0 0 0 1 1c
tx 0 0 0 0 0 0 0 1f
rx 7 1 0 1 1 0 0 1b
rx 3 1 1 0 0 0 0 0c
tx 3 9 0 0 0 0 0 0c

// File: tb.f
+incdir+include
logic/bb_pkg.sv
logic/hec_lfsr.sv
logic/hdr_rx.sv
logic/arq_link.sv
logic/hdr_tx.sv
logic/bitproc_top.sv
tests/bitproc_monitor.sv
tests/bitproc_chk.sv
tests/tb_top.sv

// File: Bender.yml
package:
  name: bt_bitproc

export_include_dirs:
  - include

sources:
  - logic/bb_pkg.sv
  - logic/hec_lfsr.sv
  - logic/hdr_rx.sv
  - logic/arq_link.sv
  - logic/hdr_tx.sv
  - logic/bitproc_top.sv
  - target: test
    files:
      - tests/bitproc_monitor.sv
      - tests/bitproc_chk.sv
      - tests/tb_top.sv

// File: tests/tb_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "bb_defines.svh"

module tb_top;
  import bb_pkg::*;

  // one line of the vector file
  typedef struct packed {
    logic        tx;
    lt_addr_t    lt;
    pk_type_t    pk_type;
    logic        flow;
    logic        arqn;
    logic        seqn;
    logic        bad;
    logic        rbs;
    link_state_t exp;
  } vec_t;

  logic        clk_6M;
  logic        rstz;
  logic        bit_p;
  logic        rxbit;
  logic        rx_header_st_p;
  logic        tx_start_p;
  lt_addr_t    tx_lt_addr;
  pk_type_t    tx_pk_type;
  logic        rx_buf_stop;
  uap_t        uap;
  rx_update_t  rx_upd;
  logic        lt_addressed;
  logic        rxispoll;
  link_state_t [`BB_NUM_LINKS-1:0] link_st;
  logic        txbit;
  logic        txbit_period;
  logic        tx_endp;
  logic        sendoldpy;

  logic [2:0]  div;
  vec_t        cur;
  logic        test_go;
  logic        test_done;
  int          pass_cnt;
  int          fail_cnt;
  vec_t        vecs[$];
  longint      limit_ns;
  bit          read_ok;

  bitproc_top dut_i (
    .clk_6M         (clk_6M        ),
    .rstz           (rstz          ),
    .bit_p          (bit_p         ),
    .rxbit          (rxbit         ),
    .rx_header_st_p (rx_header_st_p),
    .tx_start_p     (tx_start_p    ),
    .tx_lt_addr     (tx_lt_addr    ),
    .tx_pk_type     (tx_pk_type    ),
    .rx_buf_stop    (rx_buf_stop   ),
    .uap            (uap           ),
    .rx_upd         (rx_upd        ),
    .lt_addressed   (lt_addressed  ),
    .rxispoll       (rxispoll      ),
    .link_st        (link_st       ),
    .txbit          (txbit         ),
    .txbit_period   (txbit_period  ),
    .tx_endp        (tx_endp       ),
    .sendoldpy      (sendoldpy     )
  );

  bitproc_monitor mon_i (
    .clk_6M       (clk_6M      ),
    .rstz         (rstz        ),
    .bit_p        (bit_p       ),
    .uap          (uap         ),
    .test_go      (test_go     ),
    .test_tx      (cur.tx      ),
    .test_lt      (cur.lt      ),
    .test_type    (cur.pk_type ),
    .test_flow    (cur.flow    ),
    .test_arqn    (cur.arqn    ),
    .test_seqn    (cur.seqn    ),
    .test_bad     (cur.bad     ),
    .test_rbs     (cur.rbs     ),
    .test_exp     (cur.exp     ),
    .rx_upd       (rx_upd      ),
    .lt_addressed (lt_addressed),
    .rxispoll     (rxispoll    ),
    .link_st      (link_st     ),
    .txbit        (txbit       ),
    .txbit_period (txbit_period),
    .tx_endp      (tx_endp     ),
    .sendoldpy    (sendoldpy   ),
    .test_done    (test_done   ),
    .pass_cnt     (pass_cnt    ),
    .fail_cnt     (fail_cnt    )
  );

  always #10 clk_6M = ~clk_6M;

  // bit strobe every 6 clocks
  always @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      div   <= '0;
      bit_p <= 1'b0;
    end
    else
    begin
      div   <= (div == 3'd5) ? 3'd0 : div + 3'd1;
      bit_p <= (div == 3'd5);
    end
  end

  // edge at which bit_p goes high
  task automatic wait_bit_edge();
    do
      @(posedge clk_6M);
    while (div != 3'd5);
  endtask

  task automatic read_vectors(output bit ok);
    int          fd;
    string       line;
    string       op;
    logic [31:0] f_lt, f_ty, f_fl, f_aq, f_sq, f_bad, f_rbs, f_exp;
    vec_t        v;
    ok = 0;
    fd = $fopen("tests/bitproc_vectors.txt", "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        line = "";
        if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#")
        begin
          if ($sscanf(line, "%s %h %h %h %h %h %h %h %h", op, f_lt, f_ty, f_fl,
                      f_aq, f_sq, f_bad, f_rbs, f_exp) == 9)
          begin
            v = '{tx: (op == "tx"), lt: f_lt[2:0], pk_type: f_ty[3:0], flow: f_fl[0],
                  arqn: f_aq[0], seqn: f_sq[0], bad: f_bad[0], rbs: f_rbs[0],
                  exp: f_exp[4:0]};
            vecs.push_back(v);
          end
        end
      end
      $fclose(fd);
      ok = (vecs.size() > 0);
    end
  endtask

  task automatic send_rx(input vec_t v);
    bt_header_t  hdr;
    hec_t        hec;
    logic [17:0] word;
    hdr = '{seqn: v.seqn, arqn: v.arqn, flow: v.flow, pk_type: v.pk_type, lt_addr: v.lt};
    hec = mon_i.ref_hec(uap, hdr);
    if (v.bad)
      hec = hec ^ 8'h21;    // two bits flipped
    word = {hec, hdr};
    for (int k = 0; k < 18; k++)
    begin
      wait_bit_edge();
      rxbit          <= word[k];
      rx_header_st_p <= (k == 0);
    end
  endtask

  task automatic send_tx(input vec_t v);
    tx_start_p  <= 1'b1;
    tx_lt_addr  <= v.lt;
    tx_pk_type  <= v.pk_type;
    rx_buf_stop <= v.rbs;
    @(posedge clk_6M);
    tx_start_p <= 1'b0;
    repeat (5) wait_bit_edge();
    // must be dropped, header already in flight
    tx_start_p <= 1'b1;
    tx_lt_addr <= v.lt + 3'd1;
    tx_pk_type <= ~v.pk_type;
    @(posedge clk_6M);
    tx_start_p <= 1'b0;
  endtask

  task automatic run_test(input vec_t v);
    repeat ($urandom_range(2, 9)) @(posedge clk_6M);
    cur     <= v;
    test_go <= 1'b1;
    @(posedge clk_6M);
    test_go <= 1'b0;
    if (v.tx)
      send_tx(v);
    else
      send_rx(v);
    do
      @(posedge clk_6M);
    while (!test_done);
  endtask

  initial
  begin
    void'($urandom(32'h9b38));
    clk_6M         = 1'b0;
    rstz           = 1'b0;
    rxbit          = 1'b0;
    rx_header_st_p = 1'b0;
    tx_start_p     = 1'b0;
    tx_lt_addr     = '0;
    tx_pk_type     = '0;
    rx_buf_stop    = 1'b0;
    uap            = 8'h47;
    cur            = '0;
    test_go        = 1'b0;
    read_vectors(read_ok);
    if (!read_ok)
    begin
      $display("could not read any test from tests/bitproc_vectors.txt");
      $display("TEST FAIL");
      $finish;
    end
    else
    begin
      // 30 bit times of 6 clocks per test
      limit_ns = longint'(vecs.size()) * 30 * 6 * 20 + 5000;
      fork
        begin
          #(limit_ns);
          $display("timeout, the DUT did not finish the test sequence in time");
          $display("TEST FAIL");
          $finish;
        end
      join_none
      repeat (5) @(posedge clk_6M);
      rstz <= 1'b1;
      foreach (vecs[i])
        run_test(vecs[i]);
      repeat (10) @(posedge clk_6M);
      $display("%0d tests, %0d passed, %0d failed, %0d assertion errors",
               vecs.size(), pass_cnt, fail_cnt, dut_i.chk_i.chk_errs);
      if (fail_cnt == 0 && pass_cnt == vecs.size() && dut_i.chk_i.chk_errs == 0)
        $display("TEST PASS");
      else
        $display("TEST FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tests/bitproc_chk.sv
`timescale 1ns/10ps
`default_nettype none

module bitproc_chk (
  input  wire                     clk_6M,
  input  wire                     rstz,
  input  wire                     tx_start_p,
  input  wire                     txbit,
  input  wire                     txbit_period,
  input  wire                     tx_endp,
  input  wire bb_pkg::rx_update_t rx_upd
);
  import bb_pkg::*;

  int chk_errs = 0;

  a_endp_in_period: assert property (@(posedge clk_6M) disable iff (!rstz)
    tx_endp |-> txbit_period)
  else
  begin
    $error("tx_endp outside txbit_period");
    chk_errs++;
  end

  // rx header valid is a single clock pulse
  a_valid_pulse: assert property (@(posedge clk_6M) disable iff (!rstz)
    rx_upd.valid |=> !rx_upd.valid)
  else
  begin
    $error("rx_upd.valid held longer than one clock");
    chk_errs++;
  end

  a_txbit_idle: assert property (@(posedge clk_6M) disable iff (!rstz)
    !txbit_period |-> !txbit)
  else
  begin
    $error("txbit high outside txbit_period");
    chk_errs++;
  end

  a_start_rise: assert property (@(posedge clk_6M) disable iff (!rstz)
    (tx_start_p && !txbit_period) |=> $rose(txbit_period))
  else
  begin
    $error("txbit_period did not rise one clock after tx_start_p");
    chk_errs++;
  end

endmodule

bind bitproc_top bitproc_chk chk_i (
  .clk_6M       (clk_6M      ),
  .rstz         (rstz        ),
  .tx_start_p   (tx_start_p  ),
  .txbit        (txbit       ),
  .txbit_period (txbit_period),
  .tx_endp      (tx_endp     ),
  .rx_upd       (rx_upd      )
);

`default_nettype wire

// File: tests/bitproc_monitor.sv
`timescale 1ns/10ps
`default_nettype none
`include "bb_defines.svh"

module bitproc_monitor (
  input  wire                      clk_6M,
  input  wire                      rstz,
  input  wire                      bit_p,
  input  wire bb_pkg::uap_t        uap,
  input  wire                      test_go,
  input  wire                      test_tx,
  input  wire bb_pkg::lt_addr_t    test_lt,
  input  wire bb_pkg::pk_type_t    test_type,
  input  wire                      test_flow,
  input  wire                      test_arqn,
  input  wire                      test_seqn,
  input  wire                      test_bad,
  input  wire                      test_rbs,
  input  wire bb_pkg::link_state_t test_exp,
  input  wire bb_pkg::rx_update_t  rx_upd,
  input  wire                      lt_addressed,
  input  wire                      rxispoll,
  input  wire bb_pkg::link_state_t [`BB_NUM_LINKS-1:0] link_st,
  input  wire                      txbit,
  input  wire                      txbit_period,
  input  wire                      tx_endp,
  input  wire                      sendoldpy,
  output logic                     test_done,
  output int                       pass_cnt,
  output int                       fail_cnt
);
  import bb_pkg::*;

  link_state_t model [`BB_NUM_LINKS];
  int          mode;        // 0 idle, 1 rx header, 2 rx link update, 3 tx
  int          tst;
  logic        test_err;
  bt_header_t  exp_hdr;
  hec_t        exp_hec;
  logic [17:0] tx_bits;
  int          tx_cnt;
  logic        prev_period;

  // register seeded with uap, one step per header bit, lsb first
  function automatic hec_t ref_hec(uap_t seed, bt_header_t h);
    hec_t r;
    logic fb;
    r = seed;
    for (int k = 0; k < `BB_HDR_BITS; k++)
    begin
      fb = h[k] ^ r[7];
      r  = {r[6:0], 1'b0};
      if (fb)
        r = r ^ `BB_HEC_POLY;
    end
    return r;
  endfunction

  function automatic link_state_t next_state(link_state_t s, bt_header_t h, logic good);
    link_state_t n;
    n = s;
    if (!good)
      n.arqn = 1'b0;
    else
    begin
      n.remote_flow = h.flow;
      n.acked       = h.arqn;
      n.arqn        = 1'b1;
      if (h.seqn != s.seqn_old)
        n.seqn_old = h.seqn;
      if (h.arqn)
        n.tx_seqn = ~s.tx_seqn;
    end
    return n;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h exp %h", name, got, exp);
      test_err = 1'b1;
    end
  endtask

  task automatic check_links();
    for (int j = 0; j < `BB_NUM_LINKS; j++)
      check_val($sformatf("link_st[%0d]", j), 32'(link_st[j]), 32'(model[j]));
    check_val("link_st vs vector file", 32'(link_st[test_lt]), 32'(test_exp));
  endtask

  task automatic finish_test();
    if (test_err)
    begin
      fail_cnt++;
      $display("test %0d %s lt %0d: FAILED", tst, test_tx ? "tx" : "rx", test_lt);
    end
    else
    begin
      pass_cnt++;
      $display("test %0d %s lt %0d: ok", tst, test_tx ? "tx" : "rx", test_lt);
    end
    test_done <= 1'b1;
    mode = 0;
  endtask

  always @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      foreach (model[j])
        model[j] = '0;
      mode        = 0;
      tst         = 0;
      pass_cnt    = 0;
      fail_cnt    = 0;
      prev_period = 1'b0;
      test_done  <= 1'b0;
    end
    else
    begin
      test_done <= 1'b0;
      case (mode)
        0:
          if (test_go)
          begin
            tst++;
            test_err = 1'b0;
            tx_cnt   = 0;
            if (test_tx)
              exp_hdr = '{seqn: model[test_lt].tx_seqn, arqn: model[test_lt].arqn,
                          flow: ~test_rbs, pk_type: test_type, lt_addr: test_lt};
            else
              exp_hdr = '{seqn: test_seqn, arqn: test_arqn, flow: test_flow,
                          pk_type: test_type, lt_addr: test_lt};
            exp_hec = ref_hec(uap, exp_hdr);
            mode    = test_tx ? 3 : 1;
          end
        1:
          if (rx_upd.valid)
          begin
            check_val("rx_upd.hdr", 32'(rx_upd.hdr), 32'(exp_hdr));
            check_val("rx_upd.hec_good", 32'(rx_upd.hec_good), 32'(!test_bad));
            check_val("lt_addressed", 32'(lt_addressed), 32'(!test_bad && test_lt != 0));
            check_val("rxispoll", 32'(rxispoll),
                      32'(!test_bad && test_lt != 0 && test_type == `BB_TYPE_POLL));
            model[test_lt] = next_state(model[test_lt], exp_hdr, !test_bad);
            mode = 2;
          end
        2:
        begin
          check_links();
          finish_test();
        end
        3:
        begin
          if (txbit_period && !prev_period)
            check_val("sendoldpy", 32'(sendoldpy), 32'(!model[test_lt].acked));
          if (bit_p && txbit_period)
          begin
            if (tx_cnt > 0 && tx_cnt <= 18)
              tx_bits[tx_cnt-1] = txbit;
            if (tx_endp)
            begin
              if (tx_cnt != 18)
              begin
                $display("tx_endp came on bit strobe %0d instead of the 19th", tx_cnt + 1);
                test_err = 1'b1;
              end
              check_val("txbit header", 32'(tx_bits), 32'({exp_hec, exp_hdr}));
              check_links();
              finish_test();
            end
            tx_cnt++;
          end
        end
        default:
          mode = 0;
      endcase
      prev_period = txbit_period;
    end
  end

endmodule

`default_nettype wire

// File: logic/bitproc_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "bb_defines.svh"

module bitproc_top (
  input  wire                      clk_6M,
  input  wire                      rstz,
  input  wire                      bit_p,
  input  wire                      rxbit,
  input  wire                      rx_header_st_p,
  input  wire                      tx_start_p,
  input  wire bb_pkg::lt_addr_t    tx_lt_addr,
  input  wire bb_pkg::pk_type_t    tx_pk_type,
  input  wire                      rx_buf_stop,
  input  wire bb_pkg::uap_t        uap,
  output wire bb_pkg::rx_update_t  rx_upd,
  output wire                      lt_addressed,
  output wire                      rxispoll,
  output wire bb_pkg::link_state_t [`BB_NUM_LINKS-1:0] link_st,
  output wire                      txbit,
  output wire                      txbit_period,
  output wire                      tx_endp,
  output wire                      sendoldpy
);
  import bb_pkg::*;

  hdr_rx hdr_rx_u (
    .clk_6M         (clk_6M        ),
    .rstz           (rstz          ),
    .bit_p          (bit_p         ),
    .rxbit          (rxbit         ),
    .rx_header_st_p (rx_header_st_p),
    .uap            (uap           ),
    .rx_upd         (rx_upd        ),
    .lt_addressed   (lt_addressed  ),
    .rxispoll       (rxispoll      )
  );

  // one cell per lt_addr
  for (genvar i = 0; i < `BB_NUM_LINKS; i++)
  begin : g_link
    arq_link #(
      .LINK_ID (lt_addr_t'(i))
    ) arq_link_u (
      .clk_6M (clk_6M    ),
      .rstz   (rstz      ),
      .rx_upd (rx_upd    ),
      .state  (link_st[i])
    );
  end

  hdr_tx hdr_tx_u (
    .clk_6M       (clk_6M      ),
    .rstz         (rstz        ),
    .bit_p        (bit_p       ),
    .tx_start_p   (tx_start_p  ),
    .tx_lt_addr   (tx_lt_addr  ),
    .tx_pk_type   (tx_pk_type  ),
    .rx_buf_stop  (rx_buf_stop ),
    .uap          (uap         ),
    .links        (link_st     ),
    .txbit        (txbit       ),
    .txbit_period (txbit_period),
    .tx_endp      (tx_endp     ),
    .sendoldpy    (sendoldpy   )
  );

endmodule

`default_nettype wire

// File: logic/hdr_tx.sv
`timescale 1ns/10ps
`default_nettype none
`include "bb_defines.svh"

module hdr_tx (
  input  wire                      clk_6M,
  input  wire                      rstz,
  input  wire                      bit_p,
  input  wire                      tx_start_p,
  input  wire bb_pkg::lt_addr_t    tx_lt_addr,
  input  wire bb_pkg::pk_type_t    tx_pk_type,
  input  wire                      rx_buf_stop,
  input  wire bb_pkg::uap_t        uap,
  input  wire bb_pkg::link_state_t [`BB_NUM_LINKS-1:0] links,
  output logic                     txbit,
  output logic                     txbit_period,
  output logic                     tx_endp,
  output logic                     sendoldpy
);
  import bb_pkg::*;

  tx_state_t   st;
  logic [3:0]  bit_cnt;
  bt_header_t  hdr_q;
  link_state_t sel;
  hec_t        hec_calc;
  logic        start_ok;
  logic        hdr_shift;
  logic        hdr_bit;

  assign sel       = links[tx_lt_addr];
  assign start_ok  = tx_start_p & (st == IDLE);    // busy starts are dropped
  assign hdr_shift = bit_p & (st == HEADER);
  assign hdr_bit   = hdr_q[bit_cnt];
  assign tx_endp   = bit_p & (st == HEC) & (bit_cnt == 4'(`BB_HEC_W));

  hec_lfsr hec_u (
    .clk_6M (clk_6M   ),
    .rstz   (rstz     ),
    .load   (start_ok ),
    .seed   (uap      ),
    .shift  (hdr_shift),
    .din    (hdr_bit  ),
    .hec    (hec_calc )
  );

  always_ff @(posedge clk_6M)
  begin
    if (start_ok)
      hdr_q <= '{seqn:    sel.tx_seqn,
                 arqn:    sel.arqn,
                 flow:    ~rx_buf_stop,
                 pk_type: tx_pk_type,
                 lt_addr: tx_lt_addr};
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      st           <= IDLE;
      bit_cnt      <= '0;
      txbit        <= 1'b0;
      txbit_period <= 1'b0;
      sendoldpy    <= 1'b0;
    end
    else
    begin
      case (st)
        IDLE:
          if (start_ok)
          begin
            st           <= HEADER;
            bit_cnt      <= '0;
            txbit_period <= 1'b1;
            sendoldpy    <= ~sel.acked;   // last arqn was a nak
          end
        HEADER:
          if (bit_p)
          begin
            txbit <= hdr_bit;
            if (bit_cnt == 4'(`BB_HDR_BITS - 1))
            begin
              st      <= HEC;
              bit_cnt <= '0;
            end
            else
              bit_cnt <= bit_cnt + 4'd1;
          end
        HEC:
          if (tx_endp)
          begin
            st           <= IDLE;
            bit_cnt      <= '0;
            txbit        <= 1'b0;
            txbit_period <= 1'b0;
          end
          else if (bit_p)
          begin
            txbit   <= hec_calc[bit_cnt[2:0]];   // lsb first, lfsr holds still here
            bit_cnt <= bit_cnt + 4'd1;
          end
        default:
          st <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/arq_link.sv
`timescale 1ns/10ps
`default_nettype none

module arq_link #(
  parameter bb_pkg::lt_addr_t LINK_ID = '0
) (
  input  wire                     clk_6M,
  input  wire                     rstz,
  input  wire bb_pkg::rx_update_t rx_upd,
  output bb_pkg::link_state_t     state
);
  import bb_pkg::*;

  bt_header_t hdr;
  logic       hit;
  logic       new_seqn;

  assign hdr      = rx_upd.hdr;
  assign hit      = rx_upd.valid & (hdr.lt_addr == LINK_ID);
  assign new_seqn = (hdr.seqn != state.seqn_old);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      state <= '0;
    else if (hit)
    begin
      if (!rx_upd.hec_good)
        state.arqn <= 1'b0;     // nak, nothing else trusted
      else
      begin
        state.remote_flow <= hdr.flow;
        state.acked       <= hdr.arqn;
        // duplicates are acked again
        state.arqn <= 1'b1;
        if (new_seqn)
          state.seqn_old <= hdr.seqn;
        // remote acked our last packet, move on
        if (hdr.arqn)
          state.tx_seqn <= ~state.tx_seqn;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/hdr_rx.sv
`timescale 1ns/10ps
`default_nettype none
`include "bb_defines.svh"

module hdr_rx (
  input  wire                clk_6M,
  input  wire                rstz,
  input  wire                bit_p,
  input  wire                rxbit,
  input  wire                rx_header_st_p,
  input  wire bb_pkg::uap_t  uap,
  output bb_pkg::rx_update_t rx_upd,
  output logic               lt_addressed,
  output logic               rxispoll
);
  import bb_pkg::*;

  localparam int HDR_LEN = `BB_HDR_BITS + `BB_HEC_W;  // 18 bits on air

  logic [4:0]         bit_cnt;     // bits taken so far
  logic               rx_on;
  logic [HDR_LEN-1:0] rx_sr;
  logic [HDR_LEN-1:0] rx_word;
  logic               take_bit;
  logic               last_bit;
  logic               lfsr_load;
  logic               lfsr_shift;
  logic               good_now;
  hec_t               hec_calc;
  bt_header_t         hdr_now;
  bt_header_t         hdr_q;
  logic               good_q;
  logic               valid_q;

  assign take_bit   = bit_p & (rx_header_st_p | rx_on);
  assign last_bit   = bit_p & rx_on & ~rx_header_st_p & (bit_cnt == 5'(HDR_LEN - 1));
  // start strobe is held for a whole bit time
  assign lfsr_load  = bit_p & rx_header_st_p;
  // only the 10 field bits go through the lfsr
  assign lfsr_shift = take_bit & (rx_header_st_p | (bit_cnt < 5'(`BB_HDR_BITS)));

  assign rx_word  = {rxbit, rx_sr[HDR_LEN-1:1]};   // first bit ends up in bit 0
  assign hdr_now  = rx_word[`BB_HDR_BITS-1:0];
  assign good_now = (rx_word[HDR_LEN-1:`BB_HDR_BITS] == hec_calc);

  hec_lfsr hec_u (
    .clk_6M (clk_6M    ),
    .rstz   (rstz      ),
    .load   (lfsr_load ),
    .seed   (uap       ),
    .shift  (lfsr_shift),
    .din    (rxbit     ),
    .hec    (hec_calc  )
  );

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      rx_on   <= 1'b0;
      bit_cnt <= '0;
    end
    else if (bit_p)
    begin
      if (rx_header_st_p)
      begin
        rx_on   <= 1'b1;    // also restarts a header in progress
        bit_cnt <= 5'd1;
      end
      else if (last_bit)
      begin
        rx_on   <= 1'b0;
        bit_cnt <= '0;
      end
      else if (rx_on)
        bit_cnt <= bit_cnt + 5'd1;
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (take_bit)
      rx_sr <= rx_word;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      valid_q      <= 1'b0;
      lt_addressed <= 1'b0;
      rxispoll     <= 1'b0;
    end
    else
    begin
      valid_q      <= last_bit;
      lt_addressed <= last_bit & good_now & (hdr_now.lt_addr != '0);
      rxispoll     <= last_bit & good_now & (hdr_now.lt_addr != '0)
                      & (hdr_now.pk_type == `BB_TYPE_POLL);
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (last_bit)
    begin
      hdr_q  <= hdr_now;
      good_q <= good_now;
    end
  end

  assign rx_upd = '{hdr: hdr_q, hec_good: good_q, valid: valid_q};

endmodule

`default_nettype wire

// File: logic/hec_lfsr.sv
`timescale 1ns/10ps
`default_nettype none
`include "bb_defines.svh"

module hec_lfsr (
  input  wire          clk_6M,
  input  wire          rstz,
  input  wire          load,
  input  wire bb_pkg::uap_t seed,
  input  wire          shift,
  input  wire          din,
  output bb_pkg::hec_t hec
);
  import bb_pkg::*;

  hec_t base;
  logic fb;

  // load and first shift may land in the same clock
  assign base = load ? hec_t'(seed) : hec;
  assign fb   = din ^ base[`BB_HEC_W-1];

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      hec <= '0;
    else if (shift)
      hec <= {base[`BB_HEC_W-2:0], 1'b0} ^ ({`BB_HEC_W{fb}} & `BB_HEC_POLY);
    else if (load)
      hec <= base;
  end

endmodule

`default_nettype wire

// File: logic/bb_pkg.sv
`default_nettype none
`include "bb_defines.svh"

package bb_pkg;

  typedef logic [`BB_LT_W-1:0]   lt_addr_t;
  typedef logic [`BB_TYPE_W-1:0] pk_type_t;
  typedef logic [`BB_HEC_W-1:0]  hec_t;
  typedef logic [7:0]            uap_t;

  // last field first, so bit 0 is the first bit on air
  typedef struct packed {
    logic     seqn;
    logic     arqn;
    logic     flow;
    pk_type_t pk_type;
    lt_addr_t lt_addr;
  } bt_header_t;

  // broadcast to all link cells
  typedef struct packed {
    bt_header_t hdr;
    logic       hec_good;
    logic       valid;
  } rx_update_t;

  typedef struct packed {
    logic seqn_old;     // last accepted rx seqn
    logic arqn;         // ack to send next
    logic remote_flow;
    logic tx_seqn;
    logic acked;        // last rx arqn
  } link_state_t;

  typedef enum logic [1:0] {
    IDLE,
    HEADER,
    HEC
  } tx_state_t;

endpackage

`default_nettype wire

// File: include/bb_defines.svh
`ifndef BB_DEFINES_SVH
`define BB_DEFINES_SVH

// logical transports, LT_ADDR 0 included
`define BB_NUM_LINKS 8

// header field widths
`define BB_LT_W      3
`define BB_TYPE_W    4
`define BB_HEC_W     8

// lt_addr + type + flow + arqn + seqn
`define BB_HDR_BITS  10

// octal 647 with the x^8 term dropped
`define BB_HEC_POLY  8'hA7

`define BB_TYPE_POLL 4'd1

`endif
